// ==== compile.f ====
verilog/video_timing_pkg.sv
verilog/video_pattern_pkg.sv
verilog/video_sig_gen.sv
verilog/axil_pattern_regs.sv
verilog/pattern_gen.sv
verilog/video_out_stage.sv
verilog/video_pattern_top.sv
tb/video_pattern_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = video_pattern_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/video_pattern_tb.sv ====
module video_pattern_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // small raster so a frame is only a few hundred cycles
  localparam int h_act = 16;
  localparam int h_fp = 2;
  localparam int h_sw = 2;
  localparam int h_bp = 2;
  localparam int v_act = 8;
  localparam int v_fp = 1;
  localparam int v_sw = 1;
  localparam int v_bp = 1;
  localparam int frame_rate = 4;
  localparam int line_len = h_act + h_fp + h_sw + h_bp;
  localparam int frame_lines = v_act + v_fp + v_sw + v_bp;
  localparam int cycle_limit = 12 * line_len * frame_lines + 500;

  logic pixel_clk_in, rst_in;
  logic [3:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [1:0] bresp, rresp;
  logic [7:0] vid_red, vid_green, vid_blue;
  logic vid_hs, vid_vs, vid_de, frame_start, last_pixel;

  // register and raster model advanced on the rising edge
  int m_h, m_v, m_fc;
  logic m_nf, m_last, m_stop, m_bvalid;
  logic m_rvalid;
  logic [1:0] m_mode_w, m_mode_sh;
  video_pattern_pkg::pattern_cfg_u m_cfg_w, m_cfg_sh;
  logic [28:0] exp_d1 = '0;
  logic [28:0] exp_d2 = '0;  // what the outputs show now
  logic exp_wr_accept;
  logic exp_rd_accept;

  int pixel_errors = 0;
  int bus_errors = 0;
  int handshake_errors = 0;
  int cycles = 0;
  int fs_total = 0;
  int lp_total = 0;
  int lp_before;
  logic [31:0] rd_data;
  logic [1:0] rd_resp, wr_resp;
  logic [23:0] colour;
  logic [3:0] spacing;

  video_pattern_top #(
    .active_h_pixels (h_act), .h_front_porch (h_fp), .h_sync_width (h_sw),
    .h_back_porch (h_bp), .active_lines (v_act), .v_front_porch (v_fp),
    .v_sync_width (v_sw), .v_back_porch (v_bp), .fps (frame_rate)
  ) dut0 (.*);

  initial begin
    pixel_clk_in = 1'b0;
    forever #4 pixel_clk_in = ~pixel_clk_in;
  end

  // a request is taken only while no response is pending on that channel
  assign exp_wr_accept = awvalid && wvalid && !m_bvalid;
  assign exp_rd_accept = arvalid && !m_rvalid;

  // expected {r, g, b, hs, vs, de, frame_start, last_pixel} for one counter state
  function automatic logic [28:0] expected_out(input int h, input int v, input logic stop,
      input logic nf, input logic last, input logic [1:0] mode,
      input video_pattern_pkg::pattern_cfg_u cfg, input int fc);
    logic de, hs, vs, on_line;
    logic [7:0] r, g, b;
    int step;
    de = !stop && (h < h_act) && (v < v_act);
    hs = (h >= h_act + h_fp) && (h < h_act + h_fp + h_sw);
    vs = (v >= v_act + v_fp) && (v < v_act + v_fp + v_sw);
    step = 1 << cfg.grid.spacing_log2;
    on_line = (h % step == 0) || (v % step == 0);
    r = 8'd0;
    g = 8'd0;
    b = 8'd0;
    if (mode == video_pattern_pkg::mode_solid) begin
      r = cfg.solid.red;
      g = cfg.solid.green;
      b = cfg.solid.blue;
    end else if (mode == video_pattern_pkg::mode_grid && on_line) begin
      r = cfg.grid.red;
      g = cfg.grid.green;
      b = cfg.grid.blue;
    end else if (mode == video_pattern_pkg::mode_gradient) begin
      r = 8'(h);
      g = 8'(v);
      b = 8'(fc * 4);
    end
    if (!de) begin
      r = 8'd0;
      g = 8'd0;
      b = 8'd0;
    end
    return {r, g, b, hs, vs, de, nf, last};
  endfunction

  task automatic handshake_fail(input string name, input logic expv, input logic act);
    handshake_errors++;
    $display("Fail %0t %s expected %0b got %0b", $time, name, expv, act);
  endtask

  always @(posedge pixel_clk_in) begin
    if (rst_in) begin
      exp_d1 <= '0;
      exp_d2 <= '0;
      {m_h, m_v, m_fc} <= {32'd0, 32'd0, 32'd0};
      {m_nf, m_last, m_stop, m_bvalid} <= 4'b0000;
      m_rvalid <= 1'b0;
      m_mode_w <= video_pattern_pkg::mode_solid;
      m_mode_sh <= video_pattern_pkg::mode_solid;
      m_cfg_w <= '0;
      m_cfg_sh <= '0;
    end else begin
      // ready strobes seen before this edge updates the channels
      if (awready !== exp_wr_accept) handshake_fail("awready", exp_wr_accept, awready);
      if (wready !== exp_wr_accept) handshake_fail("wready", exp_wr_accept, wready);
      if (arready !== exp_rd_accept) handshake_fail("arready", exp_rd_accept, arready);
      exp_d2 <= exp_d1;  // two register stages to the pins
      exp_d1 <= expected_out(m_h, m_v, m_stop, m_nf, m_last, m_mode_sh, m_cfg_sh, m_fc);
      if (awvalid && wvalid && !m_bvalid) begin
        m_bvalid <= 1'b1;
        if (awaddr == video_pattern_pkg::addr_ctrl) begin
          m_mode_w <= wdata[1:0];
          m_stop <= wdata[8];
        end else if (awaddr == video_pattern_pkg::addr_cfg) begin
          m_cfg_w <= wdata;
        end
      end else if (m_bvalid && bready) begin
        m_bvalid <= 1'b0;
      end
      if (arvalid && !m_rvalid) begin
        m_rvalid <= 1'b1;
      end else if (m_rvalid && rready) begin
        m_rvalid <= 1'b0;
      end
      if (m_nf || m_stop) begin  // shadows follow at frame start or while parked
        m_mode_sh <= m_mode_w;
        m_cfg_sh <= m_cfg_w;
      end
      if (m_stop) begin
        {m_h, m_v} <= {32'd0, 32'd0};
        {m_nf, m_last} <= 2'b00;
      end else begin
        m_nf <= (m_h == h_act - 1) && (m_v == v_act);
        m_last <= (m_h == line_len - 1) && (m_v == frame_lines - 1);
        if (m_h == h_act - 1 && m_v == v_act) m_fc <= (m_fc + 1) % frame_rate;
        if (m_h == line_len - 1) begin
          m_h <= 0;
          m_v <= (m_v == frame_lines - 1) ? 0 : m_v + 1;
        end else begin
          m_h <= m_h + 1;
        end
      end
    end
  end

  task automatic pixel_fail(input string name, input logic [31:0] expv, input logic [31:0] act);
    pixel_errors++;
    $display("Fail %0t %s expected %0h got %0h", $time, name, expv, act);
  endtask

  task automatic bus_fail(input string name, input logic [31:0] expv, input logic [31:0] act);
    bus_errors++;
    $display("Fail %0t %s expected %0h got %0h", $time, name, expv, act);
  endtask

  // outputs settle mid-cycle
  always @(negedge pixel_clk_in) begin
    if (vid_red !== exp_d2[28:21]) pixel_fail("vid_red", 32'(exp_d2[28:21]), 32'(vid_red));
    if (vid_green !== exp_d2[20:13]) pixel_fail("vid_green", 32'(exp_d2[20:13]), 32'(vid_green));
    if (vid_blue !== exp_d2[12:5]) pixel_fail("vid_blue", 32'(exp_d2[12:5]), 32'(vid_blue));
    if (vid_hs !== exp_d2[4]) pixel_fail("vid_hs", 32'(exp_d2[4]), 32'(vid_hs));
    if (vid_vs !== exp_d2[3]) pixel_fail("vid_vs", 32'(exp_d2[3]), 32'(vid_vs));
    if (vid_de !== exp_d2[2]) pixel_fail("vid_de", 32'(exp_d2[2]), 32'(vid_de));
    if (frame_start !== exp_d2[1]) pixel_fail("frame_start", 32'(exp_d2[1]), 32'(frame_start));
    if (last_pixel !== exp_d2[0]) pixel_fail("last_pixel", 32'(exp_d2[0]), 32'(last_pixel));
    if (frame_start === 1'b1) fs_total++;
    if (last_pixel === 1'b1) lp_total++;
  end

  always @(posedge pixel_clk_in) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("errors: pixel %0d, bus %0d, handshake %0d", pixel_errors, bus_errors,
               handshake_errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // bus tasks start and end on a falling edge
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
      output logic [1:0] resp);
    int delay;
    delay = $urandom_range(0, 3);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge pixel_clk_in);
    while (bvalid !== 1'b1) @(negedge pixel_clk_in);
    awvalid = 1'b0;
    wvalid = 1'b0;
    resp = bresp;
    repeat (delay) @(negedge pixel_clk_in);  // stall on bready
    if (bvalid !== 1'b1 || bresp !== resp) begin
      bus_errors++;
      $display("write response was not held while bready was low");
    end
    bready = 1'b1;
    @(negedge pixel_clk_in);
    bready = 1'b0;
    if (bvalid !== 1'b0) bus_fail("bvalid", 32'd0, 32'(bvalid));
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
      output logic [1:0] resp);
    int delay;
    delay = $urandom_range(0, 3);
    araddr = addr;
    arvalid = 1'b1;
    @(negedge pixel_clk_in);
    while (rvalid !== 1'b1) @(negedge pixel_clk_in);
    arvalid = 1'b0;
    data = rdata;
    resp = rresp;
    repeat (delay) @(negedge pixel_clk_in);
    if (rvalid !== 1'b1 || rdata !== data || rresp !== resp) begin
      bus_errors++;
      $display("read data was not held while rready was low");
    end
    rready = 1'b1;
    @(negedge pixel_clk_in);
    rready = 1'b0;
    if (rvalid !== 1'b0) bus_fail("rvalid", 32'd0, 32'(rvalid));
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    if (resp !== 2'b00) bus_fail("bresp", 32'd0, 32'(resp));
  endtask

  task automatic wait_frame_start();
    @(negedge pixel_clk_in);
    while (frame_start !== 1'b1) @(negedge pixel_clk_in);
  endtask

  task automatic wait_active();
    @(negedge pixel_clk_in);
    while (vid_de !== 1'b1) @(negedge pixel_clk_in);
  endtask

  initial begin
    void'($urandom(32'h6a02));
    rst_in = 1'b1;
    {awaddr, araddr, wdata} = '0;
    {awvalid, wvalid, bready, arvalid, rready} = 5'b00000;
    repeat (4) @(negedge pixel_clk_in);
    rst_in = 1'b0;
    wait_frame_start();  // black raster while the syncs follow the geometry

    colour = 24'($urandom);
    reg_write(video_pattern_pkg::addr_cfg, {8'h00, colour});
    reg_write(video_pattern_pkg::addr_ctrl, 32'(video_pattern_pkg::mode_solid));
    wait_frame_start();
    wait_frame_start();

    // grid written mid-frame waits for the next frame start
    wait_active();
    repeat (20) @(negedge pixel_clk_in);
    spacing = 4'($urandom_range(1, 3));
    colour = 24'($urandom);
    reg_write(video_pattern_pkg::addr_cfg, {spacing, 4'h0, colour});
    reg_write(video_pattern_pkg::addr_ctrl, 32'(video_pattern_pkg::mode_grid));
    axi_read(video_pattern_pkg::addr_cfg, rd_data, rd_resp);
    if (rd_data !== {spacing, 4'h0, colour})
      bus_fail("rdata cfg", {spacing, 4'h0, colour}, rd_data);
    wait_frame_start();
    wait_frame_start();

    reg_write(video_pattern_pkg::addr_ctrl, 32'(video_pattern_pkg::mode_gradient));
    repeat (frame_rate) wait_frame_start();  // fc wraps on the way
    wait_active();
    axi_read(video_pattern_pkg::addr_frame, rd_data, rd_resp);
    if (rd_data !== 32'(fs_total % frame_rate))
      bus_fail("rdata frame", 32'(fs_total % frame_rate), rd_data);
    if (rd_resp !== 2'b00) bus_fail("rresp", 32'd0, 32'(rd_resp));

    reg_write(video_pattern_pkg::addr_ctrl, 32'(video_pattern_pkg::mode_gradient) | 32'h100);
    repeat (60) @(negedge pixel_clk_in);
    reg_write(video_pattern_pkg::addr_ctrl, 32'(video_pattern_pkg::mode_gradient));
    wait_frame_start();
    lp_before = lp_total;
    wait_frame_start();
    if (lp_total - lp_before != 1) begin
      bus_errors++;
      $display("last_pixel pulsed %0d times in one frame", lp_total - lp_before);
    end

    repeat (3) begin  // unmapped offset 0xc
      axi_read(4'hc, rd_data, rd_resp);
      if (rd_data !== 32'd0) bus_fail("rdata unmapped", 32'd0, rd_data);
      if (rd_resp !== 2'b10) bus_fail("rresp", 32'd2, 32'(rd_resp));
      axi_write(4'hc, $urandom, wr_resp);
      if (wr_resp !== 2'b10) bus_fail("bresp", 32'd2, 32'(wr_resp));
    end
    repeat (4) @(negedge pixel_clk_in);

    $display("errors: pixel %0d, bus %0d, handshake %0d, frames %0d", pixel_errors,
             bus_errors, handshake_errors, fs_total);
    if (pixel_errors == 0 && bus_errors == 0 && handshake_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/video_pattern_top.sv ====
module video_pattern_top #(
  parameter int active_h_pixels = video_timing_pkg::active_h_pixels,
  parameter int h_front_porch   = video_timing_pkg::h_front_porch,
  parameter int h_sync_width    = video_timing_pkg::h_sync_width,
  parameter int h_back_porch    = video_timing_pkg::h_back_porch,
  parameter int active_lines    = video_timing_pkg::active_lines,
  parameter int v_front_porch   = video_timing_pkg::v_front_porch,
  parameter int v_sync_width    = video_timing_pkg::v_sync_width,
  parameter int v_back_porch    = video_timing_pkg::v_back_porch,
  parameter int fps             = video_timing_pkg::fps
) (
  input  logic        pixel_clk_in,
  input  logic        rst_in,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output logic [7:0]  vid_red,
  output logic [7:0]  vid_green,
  output logic [7:0]  vid_blue,
  output logic        vid_hs,
  output logic        vid_vs,
  output logic        vid_de,
  output logic        frame_start,
  output logic        last_pixel
);

  logic                                video_gen_stop;
  logic [1:0]                          mode;
  video_pattern_pkg::pattern_cfg_u      cfg;

  // timing generator outputs
  logic [video_timing_pkg::hcount_w-1:0] hcount;
  logic [video_timing_pkg::vcount_w-1:0] vcount;
  logic                                hs;
  logic                                vs;
  logic                                ad;
  logic                                nf;
  logic                                very_last_pixel;
  logic [video_timing_pkg::fc_w-1:0]     fc;

  // pattern stage outputs
  logic [7:0] pat_red;
  logic [7:0] pat_green;
  logic [7:0] pat_blue;
  logic       hs_d;
  logic       vs_d;
  logic       ad_d;
  logic       nf_d;
  logic       last_d;

  axil_pattern_regs regs0 (
    .pixel_clk_in   (pixel_clk_in),
    .rst_in         (rst_in),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .nf             (nf),
    .fc             (fc),
    .video_gen_stop (video_gen_stop),
    .mode           (mode),
    .cfg            (cfg)
  );

  video_sig_gen #(
    .active_h_pixels (active_h_pixels),
    .h_front_porch   (h_front_porch),
    .h_sync_width    (h_sync_width),
    .h_back_porch    (h_back_porch),
    .active_lines    (active_lines),
    .v_front_porch   (v_front_porch),
    .v_sync_width    (v_sync_width),
    .v_back_porch    (v_back_porch),
    .fps             (fps)
  ) timing0 (
    .pixel_clk_in        (pixel_clk_in),
    .rst_in              (rst_in),
    .video_gen_stop      (video_gen_stop),
    .hcount_out          (hcount),
    .vcount_out          (vcount),
    .vs_out              (vs),
    .hs_out              (hs),
    .ad_out              (ad),
    .nf_out              (nf),
    .very_last_pixel_out (very_last_pixel),
    .fc_out              (fc)
  );

  pattern_gen pattern0 (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .hcount       (hcount),
    .vcount       (vcount),
    .hs           (hs),
    .vs           (vs),
    .ad           (ad),
    .nf           (nf),
    .last         (very_last_pixel),
    .fc           (fc),
    .mode         (mode),
    .cfg          (cfg),
    .red          (pat_red),
    .green        (pat_green),
    .blue         (pat_blue),
    .hs_d         (hs_d),
    .vs_d         (vs_d),
    .ad_d         (ad_d),
    .nf_d         (nf_d),
    .last_d       (last_d)
  );

  video_out_stage out0 (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .red          (pat_red),
    .green        (pat_green),
    .blue         (pat_blue),
    .hs           (hs_d),
    .vs           (vs_d),
    .ad           (ad_d),
    .nf           (nf_d),
    .last         (last_d),
    .vid_red      (vid_red),
    .vid_green    (vid_green),
    .vid_blue     (vid_blue),
    .vid_hs       (vid_hs),
    .vid_vs       (vid_vs),
    .vid_de       (vid_de),
    .frame_start  (frame_start),
    .last_pixel   (last_pixel)
  );

endmodule

// ==== verilog/video_out_stage.sv ====
module video_out_stage (
  input  logic       pixel_clk_in,
  input  logic       rst_in,
  input  logic [7:0] red,
  input  logic [7:0] green,
  input  logic [7:0] blue,
  input  logic       hs,
  input  logic       vs,
  input  logic       ad,
  input  logic       nf,
  input  logic       last,
  output logic [7:0] vid_red,
  output logic [7:0] vid_green,
  output logic [7:0] vid_blue,
  output logic       vid_hs,
  output logic       vid_vs,
  output logic       vid_de,
  output logic       frame_start,
  output logic       last_pixel
);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      vid_red     <= 8'd0;
      vid_green   <= 8'd0;
      vid_blue    <= 8'd0;
      vid_hs      <= 1'b0;
      vid_vs      <= 1'b0;
      vid_de      <= 1'b0;
      frame_start <= 1'b0;
      last_pixel  <= 1'b0;
    end else begin
      // colour only inside the active window
      vid_red     <= ad ? red : 8'd0;
      vid_green   <= ad ? green : 8'd0;
      vid_blue    <= ad ? blue : 8'd0;
      vid_hs      <= hs;
      vid_vs      <= vs;
      vid_de      <= ad;
      frame_start <= nf;
      last_pixel  <= last;
    end
  end

endmodule

// ==== verilog/pattern_gen.sv ====
module pattern_gen (
  input  logic                                pixel_clk_in,
  input  logic                                rst_in,
  input  logic [video_timing_pkg::hcount_w-1:0] hcount,
  input  logic [video_timing_pkg::vcount_w-1:0] vcount,
  input  logic                                hs,
  input  logic                                vs,
  input  logic                                ad,
  input  logic                                nf,
  input  logic                                last,
  input  logic [video_timing_pkg::fc_w-1:0]     fc,
  input  logic [1:0]                          mode,
  input  video_pattern_pkg::pattern_cfg_u      cfg,
  output logic [7:0]                          red,
  output logic [7:0]                          green,
  output logic [7:0]                          blue,
  output logic                                hs_d,
  output logic                                vs_d,
  output logic                                ad_d,
  output logic                                nf_d,
  output logic                                last_d
);

  localparam int hw = video_timing_pkg::hcount_w;
  localparam int vw = video_timing_pkg::vcount_w;

  logic [15:0] grid_mask;
  logic        on_line;
  logic [7:0]  red_next;
  logic [7:0]  green_next;
  logic [7:0]  blue_next;

  // low spacing_log2 bits all zero on either axis -> grid line
  assign grid_mask = (16'd1 << cfg.grid.spacing_log2) - 16'd1;
  assign on_line   = ((hcount & grid_mask[hw-1:0]) == '0) ||
                     ((vcount & grid_mask[vw-1:0]) == '0);

  always_comb begin
    red_next   = 8'd0;
    green_next = 8'd0;
    blue_next  = 8'd0;
    case (mode)
      video_pattern_pkg::mode_solid: begin
        red_next   = cfg.solid.red;
        green_next = cfg.solid.green;
        blue_next  = cfg.solid.blue;
      end
      video_pattern_pkg::mode_grid: begin
        if (on_line) begin
          red_next   = cfg.grid.red;
          green_next = cfg.grid.green;
          blue_next  = cfg.grid.blue;
        end
      end
      video_pattern_pkg::mode_gradient: begin
        red_next   = hcount[7:0];
        green_next = vcount[7:0];
        blue_next  = 8'({fc, 2'b00});  // steps per frame
      end
      default: ;  // unused code gives black
    endcase
  end

  always_ff @(posedge pixel_clk_in) begin
    red   <= red_next;
    green <= green_next;
    blue  <= blue_next;
  end

  // timing follows the pixel by the same one cycle
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      hs_d   <= 1'b0;
      vs_d   <= 1'b0;
      ad_d   <= 1'b0;
      nf_d   <= 1'b0;
      last_d <= 1'b0;
    end else begin
      hs_d   <= hs;
      vs_d   <= vs;
      ad_d   <= ad;
      nf_d   <= nf;
      last_d <= last;
    end
  end

endmodule

// ==== verilog/axil_pattern_regs.sv ====
module axil_pattern_regs (
  input  logic                            pixel_clk_in,
  input  logic                            rst_in,
  input  logic [3:0]                      awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [31:0]                     wdata,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [3:0]                      araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [31:0]                     rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,
  input  logic                            nf,
  input  logic [video_timing_pkg::fc_w-1:0] fc,
  output logic                            video_gen_stop,
  output logic [1:0]                      mode,
  output video_pattern_pkg::pattern_cfg_u  cfg
);

  logic [1:0]                     mode_reg;
  logic                           stop_reg;
  video_pattern_pkg::pattern_cfg_u cfg_reg;

  logic        wr_go;
  logic        rd_go;
  logic [31:0] rd_word;
  logic        rd_err;

  // both write channels taken in the same cycle, one outstanding response
  assign wr_go   = awvalid && wvalid && !bvalid;
  assign awready = wr_go;
  assign wready  = wr_go;

  assign rd_go   = arvalid && !rvalid;
  assign arready = rd_go;

  assign video_gen_stop = stop_reg;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      mode_reg <= video_pattern_pkg::mode_solid;
      stop_reg <= 1'b0;
      cfg_reg  <= '0;
      bvalid   <= 1'b0;
      bresp    <= video_pattern_pkg::resp_okay;
    end else if (wr_go) begin
      bvalid <= 1'b1;
      bresp  <= video_pattern_pkg::resp_okay;
      case (awaddr)
        video_pattern_pkg::addr_ctrl: begin
          mode_reg <= wdata[video_pattern_pkg::ctrl_mode_msb:video_pattern_pkg::ctrl_mode_lsb];
          stop_reg <= wdata[video_pattern_pkg::ctrl_stop_bit];
        end
        video_pattern_pkg::addr_cfg:   cfg_reg <= wdata;
        video_pattern_pkg::addr_frame: bresp   <= video_pattern_pkg::resp_okay;  // read only
        default:                       bresp   <= video_pattern_pkg::resp_slverr;
      endcase
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end
  end

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (araddr)
      video_pattern_pkg::addr_ctrl: begin
        rd_word[video_pattern_pkg::ctrl_mode_msb:video_pattern_pkg::ctrl_mode_lsb] = mode_reg;
        rd_word[video_pattern_pkg::ctrl_stop_bit] = stop_reg;
      end
      video_pattern_pkg::addr_cfg:   rd_word = cfg_reg;
      video_pattern_pkg::addr_frame: rd_word = 32'(fc);
      default:                       rd_err  = 1'b1;  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      rvalid <= 1'b0;
      rresp  <= video_pattern_pkg::resp_okay;
    end else if (rd_go) begin
      rvalid <= 1'b1;
      rresp  <= rd_err ? video_pattern_pkg::resp_slverr : video_pattern_pkg::resp_okay;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rd_go) begin
      rdata <= rd_word;
    end
  end

  // pipeline sees new settings only at frame boundary, or freely when parked
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      mode <= video_pattern_pkg::mode_solid;
      cfg  <= '0;
    end else if (nf || stop_reg) begin
      mode <= mode_reg;
      cfg  <= cfg_reg;
    end
  end

endmodule

// ==== verilog/video_sig_gen.sv ====
module video_sig_gen #(
  parameter int active_h_pixels = video_timing_pkg::active_h_pixels,
  parameter int h_front_porch   = video_timing_pkg::h_front_porch,
  parameter int h_sync_width    = video_timing_pkg::h_sync_width,
  parameter int h_back_porch    = video_timing_pkg::h_back_porch,
  parameter int active_lines    = video_timing_pkg::active_lines,
  parameter int v_front_porch   = video_timing_pkg::v_front_porch,
  parameter int v_sync_width    = video_timing_pkg::v_sync_width,
  parameter int v_back_porch    = video_timing_pkg::v_back_porch,
  parameter int fps             = video_timing_pkg::fps
) (
  input  logic                                pixel_clk_in,
  input  logic                                rst_in,
  input  logic                                video_gen_stop,
  output logic [video_timing_pkg::hcount_w-1:0] hcount_out,
  output logic [video_timing_pkg::vcount_w-1:0] vcount_out,
  output logic                                vs_out,
  output logic                                hs_out,
  output logic                                ad_out,  // active drawing area
  output logic                                nf_out,  // new frame strobe
  output logic                                very_last_pixel_out,
  output logic [video_timing_pkg::fc_w-1:0]     fc_out
);

  localparam int hw = video_timing_pkg::hcount_w;
  localparam int vw = video_timing_pkg::vcount_w;
  localparam int fw = video_timing_pkg::fc_w;

  localparam int line_length = active_h_pixels + h_front_porch + h_sync_width + h_back_porch;
  localparam int total_lines = active_lines + v_front_porch + v_sync_width + v_back_porch;

  localparam logic [hw-1:0] last_h = hw'(line_length - 1);
  localparam logic [vw-1:0] last_v = vw'(total_lines - 1);

  localparam logic [hw-1:0] h_active     = hw'(active_h_pixels);
  localparam logic [vw-1:0] v_active     = vw'(active_lines);
  localparam logic [hw-1:0] h_sync_start = hw'(active_h_pixels + h_front_porch);
  localparam logic [hw-1:0] h_sync_end   = hw'(active_h_pixels + h_front_porch + h_sync_width);
  localparam logic [vw-1:0] v_sync_start = vw'(active_lines + v_front_porch);
  localparam logic [vw-1:0] v_sync_end   = vw'(active_lines + v_front_porch + v_sync_width);

  // frame strobe fires one pixel after the end of the first blank line's active part
  localparam logic [hw-1:0] h_nf = hw'(active_h_pixels - 1);
  localparam logic [vw-1:0] v_nf = vw'(active_lines);

  localparam logic [fw-1:0] fc_last = fw'(fps - 1);

  logic at_nf;
  logic at_end;

  assign at_nf  = (hcount_out == h_nf) && (vcount_out == v_nf);
  assign at_end = (hcount_out == last_h) && (vcount_out == last_v);

  // sync windows and active area straight off the counters
  always_comb begin
    hs_out = (hcount_out >= h_sync_start) && (hcount_out < h_sync_end);
    vs_out = (vcount_out >= v_sync_start) && (vcount_out < v_sync_end);
    ad_out = !video_gen_stop && (hcount_out < h_active) && (vcount_out < v_active);
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      hcount_out          <= '0;
      vcount_out          <= '0;
      nf_out              <= 1'b0;
      very_last_pixel_out <= 1'b0;
      fc_out              <= '0;
    end else if (video_gen_stop) begin
      hcount_out          <= '0;  // park at origin, fc untouched
      vcount_out          <= '0;
      nf_out              <= 1'b0;
      very_last_pixel_out <= 1'b0;
    end else begin
      nf_out              <= at_nf;
      very_last_pixel_out <= at_end;  // shows up with (0,0) of next frame
      if (at_nf) begin
        fc_out <= (fc_out == fc_last) ? '0 : fc_out + 1'b1;
      end
      if (hcount_out == last_h) begin
        hcount_out <= '0;
        vcount_out <= (vcount_out == last_v) ? '0 : vcount_out + 1'b1;
      end else begin
        hcount_out <= hcount_out + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/video_pattern_pkg.sv ====
package video_pattern_pkg;

  // pattern select codes
  localparam logic [1:0] mode_solid    = 2'd0;
  localparam logic [1:0] mode_grid     = 2'd1;
  localparam logic [1:0] mode_gradient = 2'd2;

  // register map, byte offsets
  localparam logic [3:0] addr_ctrl  = 4'h0;
  localparam logic [3:0] addr_cfg   = 4'h4;
  localparam logic [3:0] addr_frame = 4'h8;

  // ctrl register fields
  localparam int ctrl_mode_lsb = 0;
  localparam int ctrl_mode_msb = 1;
  localparam int ctrl_stop_bit = 8;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // one config word, read differently per mode; gradient ignores it
  typedef union packed {
    struct packed {
      logic [7:0] pad;
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
    } solid;
    struct packed {
      logic [3:0] spacing_log2;  // line every 2**n pixels
      logic [3:0] pad;
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
    } grid;
  } pattern_cfg_u;

endpackage

// ==== verilog/video_timing_pkg.sv ====
package video_timing_pkg;

  // 1280x720 at 60 Hz, 74.25 MHz pixel clock
  localparam int active_h_pixels = 1280;
  localparam int h_front_porch   = 110;
  localparam int h_sync_width    = 40;
  localparam int h_back_porch    = 220;

  localparam int active_lines  = 720;
  localparam int v_front_porch = 5;
  localparam int v_sync_width  = 5;
  localparam int v_back_porch  = 20;

  localparam int fps = 60;  // frame counter wraps here

  // 1650 pixels per line, 750 lines per frame
  localparam int hcount_w = 11;
  localparam int vcount_w = 10;

  localparam int fc_w = 6;  // holds 0..fps-1

endpackage
